//--- src/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath width, shared by PC, targets and extended immediate
`define XLEN 32

// GPR index width, 32 architectural registers
`define REG_ADDR_W 5

`endif

//--- src/isa_pkg.sv
`include "decode_settings.svh"

package isa_pkg;

    // Primary opcodes, encodings as used by the existing decoder
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,             // R-type, decoded on funct
        OP_REGIMM  = 6'b000001,             // Branches decoded on rt
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,             // Zero-extended imm
        OP_ORI     = 6'b001101,             // Zero-extended imm
        OP_XORI    = 6'b001110,             // Zero-extended imm
        OP_LUI     = 6'b001111,             // Handled as a load variant
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LWL     = 6'b100010,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_LWR     = 6'b100110,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    // SPECIAL function codes with dedicated handling
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_MTHI = 6'b010001,
        FN_MTLO = 6'b010100,                // Legacy encoding kept
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // REGIMM rt selectors
    localparam logic [`REG_ADDR_W-1:0] RT_BLTZ   = 5'b00000;
    localparam logic [`REG_ADDR_W-1:0] RT_BGEZ   = 5'b00001;
    localparam logic [`REG_ADDR_W-1:0] RT_BLTZAL = 5'b10000;   // With link
    localparam logic [`REG_ADDR_W-1:0] RT_BGEZAL = 5'b10001;   // With link

    typedef struct packed {
        opcode_e                op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        funct_e                 funct;
    } r_fields_t;

    typedef struct packed {
        opcode_e                op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } i_fields_t;

    // Same word seen as R-type, I-type or raw (J index in raw[25:0])
    typedef union packed {
        r_fields_t        r;
        i_fields_t        i;
        logic [`XLEN-1:0] raw;
    } instr_u;

    // Stage 1 to stage 2 bundle
    typedef struct packed {
        logic             valid;
        instr_u           instr;
        logic [`XLEN-1:0] pc_plus4;
        logic [`XLEN-1:0] branch_target;
        logic [`XLEN-1:0] jump_target;
    } fetch_t;

endpackage

//--- src/ctrl_pkg.sv
`include "decode_settings.svh"

package ctrl_pkg;

    typedef enum logic [1:0] {
        REGDST_RT   = 2'b00,                // I-type destination
        REGDST_RD   = 2'b01,                // R-type destination
        REGDST_RA31 = 2'b10                 // Link register
    } regdst_e;

    // Writeback source, former memtoreg pair
    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,
        WB_MEM  = 2'b01,
        WB_LINK = 2'b10                     // PC+8 style return address
    } wbsel_e;

    // Former jump and jump1 pair
    typedef enum logic [1:0] {
        JUMP_NONE   = 2'b00,
        JUMP_TARGET = 2'b01,                // Pseudo-direct J/JAL
        JUMP_REG    = 2'b10                 // JR/JALR through rs
    } jump_e;

    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,                // Address calc
        ALUOP_SUB   = 2'b01,                // Branch compare
        ALUOP_FUNCT = 2'b10,                // Look at funct
        ALUOP_IMM   = 2'b11                 // Look at opcode
    } aluop_e;

    typedef enum logic [2:0] {
        LD_LB  = 3'b000,
        LD_LBU = 3'b001,
        LD_LH  = 3'b010,
        LD_LHU = 3'b011,
        LD_LUI = 3'b100,
        LD_LW  = 3'b101,                    // Idle value
        LD_LWL = 3'b110,
        LD_LWR = 3'b111
    } load_ctrl_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_MTHI, ALU_MTLO
    } alu_func_e;

    typedef struct packed {
        logic       regwrite;
        regdst_e    regdst;
        logic       alusrc;                 // Immediate as operand B
        logic       branch;
        logic       mem_write;
        wbsel_e     wbsel;
        jump_e      jump;
        aluop_e     aluop;
        load_ctrl_e load_ctrl;
        logic       illegal;
    } ctrl_word_t;

    // All-inactive control word
    localparam ctrl_word_t CTRL_IDLE = '{
        regwrite:  1'b0,
        regdst:    REGDST_RT,
        alusrc:    1'b0,
        branch:    1'b0,
        mem_write: 1'b0,
        wbsel:     WB_ALU,
        jump:      JUMP_NONE,
        aluop:     ALUOP_ADD,
        load_ctrl: LD_LW,
        illegal:   1'b0
    };

    // Registered decode result
    typedef struct packed {
        logic                   valid;
        ctrl_word_t             ctrl;
        alu_func_e              alu_func;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [`XLEN-1:0]       imm_ext;
        logic [`XLEN-1:0]       pc_plus4;
        logic [`XLEN-1:0]       branch_target;
        logic [`XLEN-1:0]       jump_target;
    } decoded_t;

endpackage

//--- src/target_stage.sv
`include "decode_settings.svh"

module target_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  isa_pkg::instr_u  in_instr,
    input  logic [`XLEN-1:0] in_pc,
    output isa_pkg::fetch_t  fetch
);

    logic [`XLEN-1:0] pc_plus4;             // Sequential PC
    logic [`XLEN-1:0] br_offset;            // Sign-extended word offset
    logic [`XLEN-1:0] br_target;
    logic [`XLEN-1:0] j_target;

    assign pc_plus4 = in_pc + `XLEN'd4;

    // imm << 2 with sign fill
    assign br_offset = {{(`XLEN-18){in_instr.i.imm[15]}}, in_instr.i.imm, 2'b00};

    assign br_target = pc_plus4 + br_offset;     // Relative to delay slot PC

    // Region bits from PC+4, index from instr
    assign j_target = {pc_plus4[`XLEN-1:`XLEN-4], in_instr.raw[25:0], 2'b00};

    // Targets computed for every word, stage 2 picks what applies
    always_ff @(posedge clk) begin
        fetch.instr         <= in_instr;
        fetch.pc_plus4      <= pc_plus4;
        fetch.branch_target <= br_target;
        fetch.jump_target   <= j_target;
        if (!rst_n) begin
            fetch.valid <= 1'b0;            // Only control bit here
        end else begin
            fetch.valid <= in_valid;
        end
    end

endmodule

//--- src/main_decoder.sv
`include "decode_settings.svh"

module main_decoder (
    input  isa_pkg::opcode_e       op,
    input  isa_pkg::funct_e        funct,
    input  logic [`REG_ADDR_W-1:0] rt,      // REGIMM selector
    output ctrl_pkg::ctrl_word_t   ctrl
);

    always_comb begin
        ctrl = ctrl_pkg::CTRL_IDLE;                             // Start inactive
        case (op)
            isa_pkg::OP_SPECIAL: begin
                case (funct)
                    isa_pkg::FN_JR: begin
                        ctrl.jump = ctrl_pkg::JUMP_REG;         // Target in rs
                    end
                    isa_pkg::FN_JALR: begin
                        ctrl.jump     = ctrl_pkg::JUMP_REG;
                        ctrl.regwrite = 1'b1;
                        ctrl.regdst   = ctrl_pkg::REGDST_RA31;  // Return addr to $31
                        ctrl.wbsel    = ctrl_pkg::WB_LINK;
                    end
                    isa_pkg::FN_MTHI, isa_pkg::FN_MTLO: begin
                        // HI/LO sit inside the ALU, no GPR write
                        ctrl.aluop = ctrl_pkg::ALUOP_FUNCT;
                    end
                    default: begin
                        ctrl.regwrite = 1'b1;                   // Plain R-type
                        ctrl.regdst   = ctrl_pkg::REGDST_RD;
                        ctrl.aluop    = ctrl_pkg::ALUOP_FUNCT;
                    end
                endcase
            end

            isa_pkg::OP_LB, isa_pkg::OP_LBU, isa_pkg::OP_LH, isa_pkg::OP_LHU,
            isa_pkg::OP_LUI, isa_pkg::OP_LW, isa_pkg::OP_LWL, isa_pkg::OP_LWR: begin
                ctrl.regwrite = 1'b1;
                ctrl.alusrc   = 1'b1;                           // Base + offset
                ctrl.wbsel    = ctrl_pkg::WB_MEM;
                case (op)                                       // Select load flavour
                    isa_pkg::OP_LB:  ctrl.load_ctrl = ctrl_pkg::LD_LB;
                    isa_pkg::OP_LBU: ctrl.load_ctrl = ctrl_pkg::LD_LBU;
                    isa_pkg::OP_LH:  ctrl.load_ctrl = ctrl_pkg::LD_LH;
                    isa_pkg::OP_LHU: ctrl.load_ctrl = ctrl_pkg::LD_LHU;
                    isa_pkg::OP_LUI: ctrl.load_ctrl = ctrl_pkg::LD_LUI;
                    isa_pkg::OP_LWL: ctrl.load_ctrl = ctrl_pkg::LD_LWL;
                    isa_pkg::OP_LWR: ctrl.load_ctrl = ctrl_pkg::LD_LWR;
                    default:         ctrl.load_ctrl = ctrl_pkg::LD_LW;
                endcase
            end

            isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW: begin
                ctrl.alusrc    = 1'b1;                          // Address calc
                ctrl.mem_write = 1'b1;
            end

            isa_pkg::OP_BEQ, isa_pkg::OP_BNE, isa_pkg::OP_BLEZ, isa_pkg::OP_BGTZ: begin
                ctrl.branch = 1'b1;
                ctrl.aluop  = ctrl_pkg::ALUOP_SUB;              // Compare by subtract
            end

            isa_pkg::OP_REGIMM: begin
                case (rt)
                    isa_pkg::RT_BLTZ, isa_pkg::RT_BGEZ: begin
                        ctrl.branch = 1'b1;
                        ctrl.aluop  = ctrl_pkg::ALUOP_SUB;
                    end
                    isa_pkg::RT_BLTZAL, isa_pkg::RT_BGEZAL: begin
                        ctrl.branch   = 1'b1;
                        ctrl.aluop    = ctrl_pkg::ALUOP_SUB;
                        ctrl.regwrite = 1'b1;                   // Link even if not taken
                        ctrl.regdst   = ctrl_pkg::REGDST_RA31;
                        ctrl.wbsel    = ctrl_pkg::WB_LINK;
                    end
                    default: begin
                        ctrl.illegal = 1'b1;                    // Unsupported rt code
                    end
                endcase
            end

            isa_pkg::OP_J: begin
                ctrl.jump = ctrl_pkg::JUMP_TARGET;
            end
            isa_pkg::OP_JAL: begin
                ctrl.jump     = ctrl_pkg::JUMP_TARGET;
                ctrl.regwrite = 1'b1;
                ctrl.regdst   = ctrl_pkg::REGDST_RA31;
                ctrl.wbsel    = ctrl_pkg::WB_LINK;
            end

            isa_pkg::OP_ADDIU, isa_pkg::OP_ANDI, isa_pkg::OP_ORI,
            isa_pkg::OP_XORI, isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU: begin
                ctrl.regwrite = 1'b1;                           // Result to rt
                ctrl.alusrc   = 1'b1;
                ctrl.aluop    = ctrl_pkg::ALUOP_IMM;
            end

            default: begin
                ctrl.illegal = 1'b1;                            // Unknown opcode
            end
        endcase
    end

endmodule

//--- src/alu_decoder.sv
module alu_decoder (
    input  ctrl_pkg::aluop_e    aluop,
    input  isa_pkg::opcode_e    op,     // Used for immediate class
    input  isa_pkg::funct_e     funct,  // Used for funct class
    output ctrl_pkg::alu_func_e alu_func
);

    always_comb begin
        alu_func = ctrl_pkg::ALU_ADD;                           // Safe fallback
        case (aluop)
            ctrl_pkg::ALUOP_ADD: alu_func = ctrl_pkg::ALU_ADD;  // Loads, stores, jumps
            ctrl_pkg::ALUOP_SUB: alu_func = ctrl_pkg::ALU_SUB;  // Branch compare
            ctrl_pkg::ALUOP_FUNCT: begin
                case (funct)
                    isa_pkg::FN_ADDU: alu_func = ctrl_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: alu_func = ctrl_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  alu_func = ctrl_pkg::ALU_AND;
                    isa_pkg::FN_OR:   alu_func = ctrl_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  alu_func = ctrl_pkg::ALU_XOR;
                    isa_pkg::FN_NOR:  alu_func = ctrl_pkg::ALU_NOR;
                    isa_pkg::FN_SLT:  alu_func = ctrl_pkg::ALU_SLT;
                    isa_pkg::FN_SLTU: alu_func = ctrl_pkg::ALU_SLTU;
                    isa_pkg::FN_SLL:  alu_func = ctrl_pkg::ALU_SLL;     // Shift by shamt
                    isa_pkg::FN_SRL:  alu_func = ctrl_pkg::ALU_SRL;
                    isa_pkg::FN_SRA:  alu_func = ctrl_pkg::ALU_SRA;
                    isa_pkg::FN_MTHI: alu_func = ctrl_pkg::ALU_MTHI;    // Load HI
                    isa_pkg::FN_MTLO: alu_func = ctrl_pkg::ALU_MTLO;    // Load LO
                    default:          alu_func = ctrl_pkg::ALU_ADD;     // Unlisted funct
                endcase
            end
            ctrl_pkg::ALUOP_IMM: begin
                case (op)
                    isa_pkg::OP_ANDI:  alu_func = ctrl_pkg::ALU_AND;
                    isa_pkg::OP_ORI:   alu_func = ctrl_pkg::ALU_OR;
                    isa_pkg::OP_XORI:  alu_func = ctrl_pkg::ALU_XOR;
                    isa_pkg::OP_SLTI:  alu_func = ctrl_pkg::ALU_SLT;
                    isa_pkg::OP_SLTIU: alu_func = ctrl_pkg::ALU_SLTU;
                    default:           alu_func = ctrl_pkg::ALU_ADD;    // ADDIU
                endcase
            end
            default: alu_func = ctrl_pkg::ALU_ADD;
        endcase
    end

endmodule

//--- src/decode_stage.sv
`include "decode_settings.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::fetch_t    fetch,
    output ctrl_pkg::decoded_t out
);

    ctrl_pkg::ctrl_word_t ctrl;             // From main decoder
    ctrl_pkg::alu_func_e  alu_func;         // From ALU decoder
    logic                 zero_ext;         // Logical immediates
    logic [`XLEN-1:0]     imm_ext;

    main_decoder u_main_decoder (
        .op    (fetch.instr.r.op),
        .funct (fetch.instr.r.funct),
        .rt    (fetch.instr.r.rt),
        .ctrl  (ctrl)
    );

    alu_decoder u_alu_decoder (
        .aluop    (ctrl.aluop),
        .op       (fetch.instr.i.op),
        .funct    (fetch.instr.r.funct),
        .alu_func (alu_func)
    );

    assign zero_ext = (fetch.instr.i.op == isa_pkg::OP_ANDI) ||
                      (fetch.instr.i.op == isa_pkg::OP_ORI)  ||
                      (fetch.instr.i.op == isa_pkg::OP_XORI);

    assign imm_ext = zero_ext ? {{(`XLEN-16){1'b0}}, fetch.instr.i.imm}
                              : {{(`XLEN-16){fetch.instr.i.imm[15]}}, fetch.instr.i.imm};

    always_ff @(posedge clk) begin
        out.alu_func      <= alu_func;
        out.rs            <= fetch.instr.r.rs;
        out.rt            <= fetch.instr.r.rt;
        out.rd            <= fetch.instr.r.rd;
        out.shamt         <= fetch.instr.r.shamt;
        out.imm_ext       <= imm_ext;
        out.pc_plus4      <= fetch.pc_plus4;
        out.branch_target <= fetch.branch_target;
        out.jump_target   <= fetch.jump_target;
        if (!rst_n) begin
            out.valid <= 1'b0;
            out.ctrl  <= ctrl_pkg::CTRL_IDLE;
        end else begin
            out.valid <= fetch.valid;
            out.ctrl  <= fetch.valid ? ctrl : ctrl_pkg::CTRL_IDLE;   // Bubble stays inert
        end
    end

endmodule

//--- src/decode_pipe.sv
`include "decode_settings.svh"

module decode_pipe (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,    // One strobe per instruction
    input  isa_pkg::instr_u    in_instr,
    input  logic [`XLEN-1:0]   in_pc,
    output ctrl_pkg::decoded_t out          // Valid two cycles after strobe
);

    isa_pkg::fetch_t fetch;                 // Stage 1 to stage 2

    // Stage 1, register word and precompute targets
    target_stage u_target_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .fetch    (fetch)
    );

    // Stage 2, decode and register bundle
    decode_stage u_decode_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .fetch (fetch),
        .out   (out)
    );

endmodule

//--- sim/tb_decode_pipe.sv
`include "decode_settings.svh"

module tb_decode_pipe;

    // Shape of the expected control word
    typedef enum {
        K_IDLE, K_RTYPE, K_HILO, K_JR, K_JALR, K_LOAD, K_STORE,
        K_BRANCH, K_BRLINK, K_J, K_JAL, K_IMM, K_ILLEGAL
    } kind_e;

    typedef struct packed {
        logic                 valid;            // Low for an idle cycle
        logic [`XLEN-1:0]     instr;
        logic [`XLEN-1:0]     pc;
        ctrl_pkg::ctrl_word_t ctrl;             // Expected control word
        ctrl_pkg::alu_func_e  alu;              // Expected ALU function
    } stim_t;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    isa_pkg::instr_u    in_instr;
    logic [`XLEN-1:0]   in_pc;
    ctrl_pkg::decoded_t out;

    stim_t stim[$];
    int    idx_q[$];                            // Entries in flight, in order
    int    due_q[$];                            // Cycle each must show up
    int    seed = 17;
    int    cycle = 0;
    int    timeout_len = 0;
    bit    checking = 1'b0;
    int    value_errors = 0;
    int    valid_errors = 0;
    int    checked = 0;

    decode_pipe DUT (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
        .in_instr(in_instr), .in_pc(in_pc), .out(out)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                       // Period 10
    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [`XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [`XLEN-1:0] op_word(input logic [5:0] op);
        logic [`XLEN-1:0] r;
        r = rand_word();
        return {op, r[25:0]};                   // Random rs, rt, imm or index
    endfunction

    function automatic logic [`XLEN-1:0] r_word(input logic [5:0] funct);
        logic [`XLEN-1:0] r;
        r = rand_word();
        return {6'b000000, r[25:6], funct};
    endfunction

    function automatic logic [`XLEN-1:0] regimm_word(input logic [4:0] rt);
        logic [`XLEN-1:0] r;
        r = rand_word();
        return {6'b000001, r[25:21], rt, r[15:0]};
    endfunction

    function automatic ctrl_pkg::ctrl_word_t expected_ctrl(input kind_e kind,
                                                           input ctrl_pkg::load_ctrl_e ld);
        ctrl_pkg::ctrl_word_t c;
        c = '{regwrite: 1'b0, regdst: ctrl_pkg::REGDST_RT, alusrc: 1'b0, branch: 1'b0,
              mem_write: 1'b0, wbsel: ctrl_pkg::WB_ALU, jump: ctrl_pkg::JUMP_NONE,
              aluop: ctrl_pkg::ALUOP_ADD, load_ctrl: ctrl_pkg::LD_LW, illegal: 1'b0};
        if (kind inside {K_RTYPE, K_JALR, K_LOAD, K_BRLINK, K_JAL, K_IMM}) c.regwrite = 1'b1;
        if (kind inside {K_JALR, K_BRLINK, K_JAL}) begin
            c.regdst = ctrl_pkg::REGDST_RA31;   // Link to $31
            c.wbsel  = ctrl_pkg::WB_LINK;
        end
        if (kind inside {K_LOAD, K_STORE, K_IMM}) c.alusrc = 1'b1;
        if (kind inside {K_BRANCH, K_BRLINK}) begin
            c.branch = 1'b1;
            c.aluop  = ctrl_pkg::ALUOP_SUB;
        end
        if (kind inside {K_RTYPE, K_HILO}) c.aluop = ctrl_pkg::ALUOP_FUNCT;
        if (kind == K_RTYPE) c.regdst = ctrl_pkg::REGDST_RD;
        if (kind inside {K_JR, K_JALR}) c.jump = ctrl_pkg::JUMP_REG;
        if (kind inside {K_J, K_JAL}) c.jump = ctrl_pkg::JUMP_TARGET;
        if (kind == K_LOAD) begin
            c.wbsel     = ctrl_pkg::WB_MEM;
            c.load_ctrl = ld;
        end
        if (kind == K_STORE) c.mem_write = 1'b1;
        if (kind == K_IMM) c.aluop = ctrl_pkg::ALUOP_IMM;
        if (kind == K_ILLEGAL) c.illegal = 1'b1;  // Everything else stays inactive
        return c;
    endfunction

    task automatic push_entry(input logic valid, input logic [`XLEN-1:0] word,
                              input ctrl_pkg::ctrl_word_t ctrl, input ctrl_pkg::alu_func_e alu);
        stim_t e;
        e.valid = valid;
        e.instr = word;
        e.pc    = rand_word() & ~`XLEN'd3;      // Word aligned
        e.ctrl  = ctrl;
        e.alu   = alu;
        stim.push_back(e);
    endtask

    task automatic add_instr(input logic [`XLEN-1:0] word, input kind_e kind,
                             input ctrl_pkg::alu_func_e alu);
        push_entry(1'b1, word, expected_ctrl(kind, ctrl_pkg::LD_LW), alu);
    endtask

    task automatic add_load(input logic [5:0] op, input ctrl_pkg::load_ctrl_e ld);
        push_entry(1'b1, op_word(op), expected_ctrl(K_LOAD, ld), ctrl_pkg::ALU_ADD);
    endtask

    task automatic add_gap();
        push_entry(1'b0, rand_word(), expected_ctrl(K_IDLE, ctrl_pkg::LD_LW), ctrl_pkg::ALU_ADD);
    endtask

    task automatic fill_table();
        add_instr(r_word(isa_pkg::FN_ADDU), K_RTYPE, ctrl_pkg::ALU_ADD);
        add_instr(r_word(isa_pkg::FN_SUBU), K_RTYPE, ctrl_pkg::ALU_SUB);
        add_instr(r_word(isa_pkg::FN_AND), K_RTYPE, ctrl_pkg::ALU_AND);
        add_instr(r_word(isa_pkg::FN_OR), K_RTYPE, ctrl_pkg::ALU_OR);
        add_instr(r_word(isa_pkg::FN_XOR), K_RTYPE, ctrl_pkg::ALU_XOR);
        add_instr(r_word(isa_pkg::FN_NOR), K_RTYPE, ctrl_pkg::ALU_NOR);
        add_instr(r_word(isa_pkg::FN_SLT), K_RTYPE, ctrl_pkg::ALU_SLT);
        add_instr(r_word(isa_pkg::FN_SLTU), K_RTYPE, ctrl_pkg::ALU_SLTU);
        add_instr(r_word(isa_pkg::FN_SLL), K_RTYPE, ctrl_pkg::ALU_SLL);
        add_instr(r_word(isa_pkg::FN_SRL), K_RTYPE, ctrl_pkg::ALU_SRL);
        add_instr(r_word(isa_pkg::FN_SRA), K_RTYPE, ctrl_pkg::ALU_SRA);
        add_instr(r_word(6'b100000), K_RTYPE, ctrl_pkg::ALU_ADD);   // Unlisted funct
        add_instr(r_word(isa_pkg::FN_MTHI), K_HILO, ctrl_pkg::ALU_MTHI);
        add_instr(r_word(isa_pkg::FN_MTLO), K_HILO, ctrl_pkg::ALU_MTLO);
        add_gap();
        add_instr(r_word(isa_pkg::FN_JR), K_JR, ctrl_pkg::ALU_ADD);
        add_instr(r_word(isa_pkg::FN_JALR), K_JALR, ctrl_pkg::ALU_ADD);
        add_load(isa_pkg::OP_LB, ctrl_pkg::LD_LB);
        add_load(isa_pkg::OP_LBU, ctrl_pkg::LD_LBU);
        add_load(isa_pkg::OP_LH, ctrl_pkg::LD_LH);
        add_load(isa_pkg::OP_LHU, ctrl_pkg::LD_LHU);
        add_load(isa_pkg::OP_LUI, ctrl_pkg::LD_LUI);
        add_load(isa_pkg::OP_LW, ctrl_pkg::LD_LW);
        add_load(isa_pkg::OP_LWL, ctrl_pkg::LD_LWL);
        add_load(isa_pkg::OP_LWR, ctrl_pkg::LD_LWR);
        add_gap();
        add_gap();
        add_instr(op_word(isa_pkg::OP_SB), K_STORE, ctrl_pkg::ALU_ADD);
        add_instr(op_word(isa_pkg::OP_SH), K_STORE, ctrl_pkg::ALU_ADD);
        add_instr(op_word(isa_pkg::OP_SW), K_STORE, ctrl_pkg::ALU_ADD);
        add_instr(op_word(isa_pkg::OP_BEQ), K_BRANCH, ctrl_pkg::ALU_SUB);
        add_instr(op_word(isa_pkg::OP_BNE), K_BRANCH, ctrl_pkg::ALU_SUB);
        add_instr(op_word(isa_pkg::OP_BLEZ), K_BRANCH, ctrl_pkg::ALU_SUB);
        add_instr(op_word(isa_pkg::OP_BGTZ), K_BRANCH, ctrl_pkg::ALU_SUB);
        add_instr(regimm_word(5'b00000), K_BRANCH, ctrl_pkg::ALU_SUB);   // BLTZ
        add_instr(regimm_word(5'b00001), K_BRANCH, ctrl_pkg::ALU_SUB);   // BGEZ
        add_instr(regimm_word(5'b10000), K_BRLINK, ctrl_pkg::ALU_SUB);   // BLTZAL
        add_instr(regimm_word(5'b10001), K_BRLINK, ctrl_pkg::ALU_SUB);   // BGEZAL
        add_instr(regimm_word(5'b00010), K_ILLEGAL, ctrl_pkg::ALU_ADD);
        add_instr(op_word(isa_pkg::OP_J), K_J, ctrl_pkg::ALU_ADD);
        add_instr(op_word(isa_pkg::OP_JAL), K_JAL, ctrl_pkg::ALU_ADD);
        // Imm bit 15 set, so zero fill and sign fill differ
        add_instr(op_word(isa_pkg::OP_ADDIU) | `XLEN'h8000, K_IMM, ctrl_pkg::ALU_ADD);
        add_instr(op_word(isa_pkg::OP_ANDI) | `XLEN'h8000, K_IMM, ctrl_pkg::ALU_AND);
        add_instr(op_word(isa_pkg::OP_ORI) | `XLEN'h8000, K_IMM, ctrl_pkg::ALU_OR);
        add_instr(op_word(isa_pkg::OP_XORI) | `XLEN'h8000, K_IMM, ctrl_pkg::ALU_XOR);
        add_instr(op_word(isa_pkg::OP_SLTI), K_IMM, ctrl_pkg::ALU_SLT);
        add_instr(op_word(isa_pkg::OP_SLTIU), K_IMM, ctrl_pkg::ALU_SLTU);
        add_instr(op_word(6'b001000), K_ILLEGAL, ctrl_pkg::ALU_ADD);     // ADDI not supported
        add_instr(op_word(6'b111111), K_ILLEGAL, ctrl_pkg::ALU_ADD);
        for (int i = 0; i < 6; i++) begin
            add_instr(op_word(isa_pkg::OP_BEQ), K_BRANCH, ctrl_pkg::ALU_SUB);
            add_instr(op_word(isa_pkg::OP_J), K_J, ctrl_pkg::ALU_ADD);
            if (i % 3 == 2) add_gap();
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_pkg::ctrl_word_t got,
                              input ctrl_pkg::ctrl_word_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h at time %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_alu(input string name, input ctrl_pkg::alu_func_e got,
                             input ctrl_pkg::alu_func_e exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h at time %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h at time %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_field(input string name, input logic [`REG_ADDR_W-1:0] got,
                               input logic [`REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h at time %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic compare_entry(input int idx);
        logic [`XLEN-1:0] word;
        logic [`XLEN-1:0] pc4;
        logic [`XLEN-1:0] imm_sx;
        logic [`XLEN-1:0] imm_zx;
        logic             logical;
        word    = stim[idx].instr;
        pc4     = stim[idx].pc + `XLEN'd4;
        imm_sx  = {{(`XLEN-16){word[15]}}, word[15:0]};
        imm_zx  = {{(`XLEN-16){1'b0}}, word[15:0]};
        logical = (word[31:26] == isa_pkg::OP_ANDI) || (word[31:26] == isa_pkg::OP_ORI) ||
                  (word[31:26] == isa_pkg::OP_XORI);   // Zero-extending ops
        checked++;
        check_ctrl("out.ctrl", out.ctrl, stim[idx].ctrl);
        check_alu("out.alu_func", out.alu_func, stim[idx].alu);
        check_field("out.rs", out.rs, word[25:21]);
        check_field("out.rt", out.rt, word[20:16]);
        check_field("out.rd", out.rd, word[15:11]);
        check_field("out.shamt", out.shamt, word[10:6]);
        check_addr("out.pc_plus4", out.pc_plus4, pc4);
        check_addr("out.branch_target", out.branch_target, pc4 + (imm_sx << 2));
        check_addr("out.jump_target", out.jump_target, {pc4[`XLEN-1:`XLEN-4], word[25:0], 2'b00});
        check_addr("out.imm_ext", out.imm_ext, logical ? imm_zx : imm_sx);
    endtask

    task automatic watch_output();
        int idx;
        int due;
        if (out.valid) begin
            if (idx_q.size() == 0) begin
                $display("Unexpected out.valid in cycle %0d with nothing in flight", cycle);
                valid_errors++;
            end else begin
                idx = idx_q.pop_front();
                due = due_q.pop_front();
                if (due != cycle) begin
                    $display("Entry %0d came out in cycle %0d instead of %0d", idx, cycle, due);
                    valid_errors++;
                end
                compare_entry(idx);
            end
        end else begin
            check_ctrl("out.ctrl", out.ctrl, expected_ctrl(K_IDLE, ctrl_pkg::LD_LW));
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                $display("Entry %0d never raised out.valid, due in cycle %0d", idx_q[0], due_q[0]);
                valid_errors++;
                idx = idx_q.pop_front();
                due = due_q.pop_front();
            end
        end
    endtask

    always @(negedge clk) begin
        if (checking) watch_output();           // Outputs settled mid-cycle
    end

    initial begin
        wait (timeout_len != 0);
        #(timeout_len);
        $display("Timeout after %0d time units with %0d entries still in flight",
                 timeout_len, idx_q.size());
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        in_pc    = '0;
        fill_table();
        timeout_len = (stim.size() + 10) * 10;
        repeat (3) @(posedge clk);
        checking = 1'b1;                        // Registers are reset by now
        #1;
        rst_n = 1'b1;
        foreach (stim[i]) begin
            @(posedge clk);
            #1;
            in_valid     = stim[i].valid;
            in_instr.raw = stim[i].instr;
            in_pc        = stim[i].pc;
            if (stim[i].valid) begin
                idx_q.push_back(i);
                due_q.push_back(cycle + 2);     // Two register stages
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (idx_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);              // Catch stray valids
        $display("Checked %0d outputs, %0d value errors, %0d valid errors",
                 checked, value_errors, valid_errors);
        if (value_errors == 0 && valid_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- decode_pipe.f
+incdir+src
src/isa_pkg.sv
src/ctrl_pkg.sv
src/target_stage.sv
src/main_decoder.sv
src/alu_decoder.sv
src/decode_stage.sv
src/decode_pipe.sv
sim/tb_decode_pipe.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_decode_pipe
DUT_TOP   := decode_pipe
FILELIST  := decode_pipe.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
